//--- project.f
verilog/dcache_pkg.sv
verilog/dcache_lookup_if.sv
verilog/dcache_ram.sv
verilog/dcache_lookup.sv
verilog/dcache_ctrl.sv
verilog/dcache_resp.sv
verilog/dcache_top.sv
tb/tb_clock.sv
tb/tb_dcache.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and check the log
rm -f sim.log
verilator --binary --timing --top-module tb_dcache -f project.f -o tb_dcache_sim \
	&& ./obj_dir/tb_dcache_sim > sim.log 2>&1 || echo "build or run error"
cat sim.log 2>/dev/null
grep -q "Test completed successfully" sim.log && exit 0 || exit 1

//--- tb/tb_dcache.sv
// Testbench top with a TileLink memory model, CPU request tasks and the directed and random tests
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

	localparam int          SETS         = 32;
	localparam int          LINE_WORDS   = 8;
	localparam logic [63:0] FILL         = 64'ha5a5_0f0f_c3c3_5a5a;
	localparam logic [3:0]  SINK_BASE    = 4'h9;
	localparam int          GNT_TIMEOUT  = 20;
	localparam int          DONE_TIMEOUT = 400;

	logic        clk;
	logic        rst_n;
	logic        req;
	logic        we;
	logic [7:0]  be;
	logic [63:0] addr;
	logic [63:0] wdata;
	logic        gnt;
	logic        rvalid;
	logic [63:0] rdata;
	logic        a_valid;
	logic        a_ready;
	logic [2:0]  a_opcode;
	logic [2:0]  a_param;
	logic [63:0] a_address;
	logic        c_valid;
	logic        c_ready;
	logic [2:0]  c_opcode;
	logic [2:0]  c_param;
	logic [63:0] c_address;
	logic [63:0] c_data;
	logic        d_valid;
	logic        d_ready;
	logic [2:0]  d_opcode;
	logic [3:0]  d_sink;
	logic [63:0] d_data;
	logic        e_valid;
	logic        e_ready;
	logic [3:0]  e_sink;

	// Memory model state
	logic [63:0] mem_q [logic [63:0]];
	logic [63:0] exp_q [logic [63:0]];
	logic [31:0] model_rng;
	bit          stall_en;
	int          gnt_left;
	int          gnt_beat;
	logic [63:0] gnt_addr;
	bit          ack_pending;
	int          c_beat;
	int          acq_count;
	int          rel_count;
	int          d_beats;
	logic [2:0]  last_a_op;
	logic [2:0]  last_a_param;
	logic [63:0] last_a_addr;
	logic [2:0]  last_c_op;
	logic [2:0]  last_c_param;
	logic [63:0] last_c_addr;
	logic [63:0] c_line [LINE_WORDS];
	logic [3:0]  sent_sink;
	logic [3:0]  seen_sink;
	int          test_errs;
	int          tests_run;
	int          tests_failed;

	tb_clock #(.PERIOD_NS(4.0), .RESET_CYCLES(2)) clock_inst (.clk_o(clk), .rst_no(rst_n));

	dcache_top #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) dcache_top_inst (
		.clk_i(clk), .rst_ni(rst_n),
		.req_i(req), .we_i(we), .be_i(be), .addr_i(addr), .wdata_i(wdata),
		.gnt_o(gnt), .rvalid_o(rvalid), .rdata_o(rdata),
		.tl_a_valid_o(a_valid), .tl_a_ready_i(a_ready), .tl_a_opcode_o(a_opcode),
		.tl_a_param_o(a_param), .tl_a_address_o(a_address),
		.tl_c_valid_o(c_valid), .tl_c_ready_i(c_ready), .tl_c_opcode_o(c_opcode),
		.tl_c_param_o(c_param), .tl_c_address_o(c_address), .tl_c_data_o(c_data),
		.tl_d_valid_i(d_valid), .tl_d_ready_o(d_ready), .tl_d_opcode_i(d_opcode),
		.tl_d_sink_i(d_sink), .tl_d_data_i(d_data),
		.tl_e_valid_o(e_valid), .tl_e_ready_i(e_ready), .tl_e_sink_o(e_sink)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [63:0] mem_word(input logic [63:0] a);
		if (mem_q.exists(a)) begin
			return mem_q[a];
		end
		return a ^ FILL;
	endfunction

	function automatic logic [63:0] exp_word(input logic [63:0] a);
		if (exp_q.exists(a)) begin
			return exp_q[a];
		end
		return a ^ FILL;
	endfunction

	// Store data replaces only the enabled bytes
	function automatic logic [63:0] merge_bytes(input logic [63:0] old_w, input logic [63:0] new_w,
		input logic [7:0] mask);
		logic [63:0] r;
		r = old_w;
		for (int b = 0; b < 8; b++) begin
			if (mask[b]) begin
				r[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return r;
	endfunction

	// TileLink manager that resolves every handshake on the falling edge
	always @(negedge clk) begin
		model_rng = xorshift32(model_rng);
		// D is served first so a grant starts one cycle after its AcquireBlock
		if (gnt_left > 0) begin
			d_valid  = 1'b1;
			d_opcode = dcache_pkg::D_GRANT_DATA;
			d_sink   = sent_sink;
			d_data   = mem_word(gnt_addr + 64'(gnt_beat * 8));
			if (d_ready) begin
				gnt_beat++;
				gnt_left--;
				d_beats++;
			end
		end else if (ack_pending) begin
			d_valid  = 1'b1;
			d_opcode = dcache_pkg::D_RELEASE_ACK;
			d_data   = '0;
			if (d_ready) begin
				ack_pending = 1'b0;
			end
		end else begin
			d_valid = 1'b0;
		end
		a_ready = stall_en ? model_rng[0] : 1'b1;
		if (a_valid && a_ready) begin
			acq_count++;
			last_a_op    = a_opcode;
			last_a_param = a_param;
			last_a_addr  = a_address;
			gnt_addr     = a_address;
			gnt_beat     = 0;
			gnt_left     = LINE_WORDS;
			sent_sink    = SINK_BASE ^ 4'(acq_count);
		end
		c_ready = stall_en ? model_rng[1] : 1'b1;
		if (c_valid && c_ready) begin
			last_c_op    = c_opcode;
			last_c_param = c_param;
			last_c_addr  = c_address;
			if (c_opcode == dcache_pkg::C_RELEASE_DATA) begin
				c_line[c_beat] = c_data;
				mem_q[c_address + 64'(c_beat * 8)] = c_data;
				c_beat++;
			end
			if (c_opcode == dcache_pkg::C_RELEASE || c_beat == LINE_WORDS) begin
				ack_pending = 1'b1;
				c_beat      = 0;
				rel_count++;
			end
		end
		e_ready = 1'b1;
		if (e_valid) begin
			seen_sink = e_sink;
		end
	end

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (exp === act) else begin
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond) else begin
			$display("Check failed: %s", what);
			test_errs++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errs == 0) begin
			$display("PASS %s", name);
		end else begin
			$display("FAIL %s with %0d errors", name, test_errs);
			tests_failed++;
		end
		test_errs = 0;
	endtask

	task automatic abort_run(input string what);
		tests_failed++;
		$display("Timed out waiting for %s", what);
		$display("Test failed");
		$finish;
	endtask

	// One CPU request with fast set for a read hit or a write without bus traffic
	task automatic cpu_access(input logic st, input logic [7:0] mask, input logic [63:0] a,
		input logic [63:0] wd, output logic [63:0] rd, output int lat, output bit fast);
		int n;
		@(negedge clk);
		req   = 1'b1;
		we    = st;
		be    = mask;
		addr  = a;
		wdata = wd;
		lat   = 0;
		fast  = 1'b0;
		rd    = '0;
		if (st) begin
			exp_q[a] = merge_bytes(exp_word(a), wd, mask);
		end
		n = 0;
		do begin
			@(negedge clk);
			req = 1'b0;
			lat++;
			n++;
		end while (!gnt && n < GNT_TIMEOUT);
		if (!gnt) begin
			abort_run("gnt_o");
		end
		if (!st) begin
			fast = rvalid;
			n = 0;
			while (!rvalid && n < DONE_TIMEOUT) begin
				@(negedge clk);
				n++;
			end
			if (!rvalid) begin
				abort_run("rvalid_o");
			end
			rd = rdata;
		end else begin
			@(negedge clk);
			fast = !(a_valid || c_valid);
			if (!fast) begin
				n = 0;
				while (!e_valid && n < DONE_TIMEOUT) begin
					@(negedge clk);
					n++;
				end
				if (!e_valid) begin
					abort_run("GrantAck on E");
				end
				n = 0;
				while (e_valid && n < GNT_TIMEOUT) begin
					@(negedge clk);
					n++;
				end
				if (e_valid) begin
					abort_run("GrantAck to be taken");
				end
				repeat (2) @(negedge clk);
			end
		end
	endtask

	initial begin
		logic [63:0] rd;
		logic [63:0] a;
		logic [31:0] r;
		int          lat;
		bit          fast;
		int          acq0;
		int          rel0;
		int          beats0;
		int          n;
		req = 1'b0;
		we = 1'b0;
		be = '0;
		addr = '0;
		wdata = '0;
		a_ready = 1'b0;
		c_ready = 1'b0;
		d_valid = 1'b0;
		d_opcode = '0;
		d_sink = '0;
		d_data = '0;
		e_ready = 1'b0;
		model_rng = 32'h5ade;
		r = 32'h5ade;
		stall_en = 1'b0;
		gnt_left = 0;
		ack_pending = 1'b0;
		c_beat = 0;
		acq_count = 0;
		rel_count = 0;
		d_beats = 0;
		test_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		n = 0;
		while (!rst_n && n < 10) begin
			@(negedge clk);
			n++;
		end
		if (!rst_n) begin
			abort_run("reset release");
		end

		// Read miss on an empty set
		acq0 = acq_count;
		beats0 = d_beats;
		cpu_access(1'b0, 8'h00, 64'h8000_0058, '0, rd, lat, fast);
		check_value("read_miss acquires", 64'(acq0 + 1), 64'(acq_count));
		check_value("read_miss a_opcode", 64'(dcache_pkg::A_ACQUIRE_BLOCK), 64'(last_a_op));
		check_value("read_miss a_param", 64'(dcache_pkg::NTOB), 64'(last_a_param));
		check_value("read_miss a_address", 64'h8000_0040, last_a_addr);
		check_value("read_miss beats", 64'(LINE_WORDS), 64'(d_beats - beats0));
		check_value("read_miss e_sink", 64'(sent_sink), 64'(seen_sink));
		check_value("read_miss rdata", exp_word(64'h8000_0058), rd);
		finish_test("read_miss");

		// Read hit on the refilled line
		acq0 = acq_count;
		cpu_access(1'b0, 8'h00, 64'h8000_0060, '0, rd, lat, fast);
		check_value("read_hit latency", 64'd1, 64'(lat));
		check_true(fast, "read hit rvalid_o did not come with gnt_o");
		check_value("read_hit acquires", 64'(acq0), 64'(acq_count));
		check_value("read_hit rdata", exp_word(64'h8000_0060), rd);
		finish_test("read_hit");

		// Store to a shared line releases it with BtoN and acquires it with NtoT
		acq0 = acq_count;
		rel0 = rel_count;
		cpu_access(1'b1, 8'h0f, 64'h8000_0058, 64'h1122_3344_5566_7788, rd, lat, fast);
		check_value("upgrade releases", 64'(rel0 + 1), 64'(rel_count));
		check_value("upgrade c_opcode", 64'(dcache_pkg::C_RELEASE), 64'(last_c_op));
		check_value("upgrade c_param", 64'(dcache_pkg::BTON), 64'(last_c_param));
		check_value("upgrade c_address", 64'h8000_0040, last_c_addr);
		check_value("upgrade acquires", 64'(acq0 + 1), 64'(acq_count));
		check_value("upgrade a_param", 64'(dcache_pkg::NTOT), 64'(last_a_param));
		cpu_access(1'b0, 8'h00, 64'h8000_0058, '0, rd, lat, fast);
		check_value("upgrade rdata", exp_word(64'h8000_0058), rd);
		finish_test("shared_store");

		// Conflict in the same set evicts the dirty line
		cpu_access(1'b0, 8'h00, 64'h8000_0848, '0, rd, lat, fast);
		check_value("evict c_opcode", 64'(dcache_pkg::C_RELEASE_DATA), 64'(last_c_op));
		check_value("evict c_param", 64'(dcache_pkg::TTON), 64'(last_c_param));
		check_value("evict c_address", 64'h8000_0040, last_c_addr);
		for (int w = 0; w < LINE_WORDS; w++) begin
			check_value("evict c_data", exp_word(64'h8000_0040 + 64'(w * 8)), c_line[w]);
		end
		check_value("evict rdata", exp_word(64'h8000_0848), rd);
		finish_test("dirty_evict");

		// Write hit on a line owned after a store miss
		cpu_access(1'b1, 8'hff, 64'h8000_0088, 64'hdead_beef_0bad_f00d, rd, lat, fast);
		acq0 = acq_count;
		rel0 = rel_count;
		cpu_access(1'b1, 8'hf0, 64'h8000_0090, 64'h0123_4567_89ab_cdef, rd, lat, fast);
		check_value("write_hit latency", 64'd1, 64'(lat));
		check_true(fast, "write hit started bus traffic");
		check_value("write_hit acquires", 64'(acq0), 64'(acq_count));
		check_value("write_hit releases", 64'(rel0), 64'(rel_count));
		cpu_access(1'b0, 8'h00, 64'h8000_0090, '0, rd, lat, fast);
		check_value("write_hit rdata", exp_word(64'h8000_0090), rd);
		cpu_access(1'b0, 8'h00, 64'h8000_0088, '0, rd, lat, fast);
		check_value("write_miss rdata", exp_word(64'h8000_0088), rd);
		finish_test("write_hit");

		// Mixed traffic with random A and C stalls
		stall_en = 1'b1;
		for (int i = 0; i < 60; i++) begin
			r = xorshift32(r);
			a = 64'h8000_0000 | (64'(r[2:1]) << 11) | (64'(r[4:3]) << 6) | (64'(r[7:5]) << 3);
			if (r[8] && r[9]) begin
				cpu_access(1'b1, r[23:16], a, {r, ~r}, rd, lat, fast);
			end else begin
				cpu_access(1'b0, 8'h00, a, '0, rd, lat, fast);
				check_value("random rdata", exp_word(a), rd);
			end
		end
		finish_test("random_mix");

		$display("Tests run %0d, failed %0d", tests_run, tests_failed);
		if (tests_failed == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
// Clock and reset generator for the testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter real PERIOD_NS    = 4.0,
	parameter int  RESET_CYCLES = 2
) (
	output logic clk_o,
	output logic rst_no
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
	end

	// Release on a falling edge, away from the flops' sampling edge
	initial begin
		rst_no = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_no = 1'b1;
	end

endmodule

`default_nettype wire

//--- verilog/dcache_top.sv
// Direct-mapped write-back data cache top with tag and data arrays and TileLink ports
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
	parameter int SETS       = 32,
	parameter int LINE_WORDS = 8
) (
	input  logic                          clk_i,
	input  logic                          rst_ni,

	// CPU port
	input  logic                          req_i,
	input  logic                          we_i,
	input  logic [dcache_pkg::BE_W-1:0]   be_i,
	input  logic [dcache_pkg::ADDR_W-1:0] addr_i,
	input  logic [dcache_pkg::DATA_W-1:0] wdata_i,
	output logic                          gnt_o,
	output logic                          rvalid_o,
	output logic [dcache_pkg::DATA_W-1:0] rdata_o,

	// TileLink A
	output logic                          tl_a_valid_o,
	input  logic                          tl_a_ready_i,
	output logic [2:0]                    tl_a_opcode_o,
	output logic [2:0]                    tl_a_param_o,
	output logic [dcache_pkg::ADDR_W-1:0] tl_a_address_o,

	// TileLink C
	output logic                          tl_c_valid_o,
	input  logic                          tl_c_ready_i,
	output logic [2:0]                    tl_c_opcode_o,
	output logic [2:0]                    tl_c_param_o,
	output logic [dcache_pkg::ADDR_W-1:0] tl_c_address_o,
	output logic [dcache_pkg::DATA_W-1:0] tl_c_data_o,

	// TileLink D
	input  logic                          tl_d_valid_i,
	output logic                          tl_d_ready_o,
	input  logic [2:0]                    tl_d_opcode_i,
	input  logic [dcache_pkg::SINK_W-1:0] tl_d_sink_i,
	input  logic [dcache_pkg::DATA_W-1:0] tl_d_data_i,

	// TileLink E
	output logic                          tl_e_valid_o,
	input  logic                          tl_e_ready_i,
	output logic [dcache_pkg::SINK_W-1:0] tl_e_sink_o
);

	localparam int IDX_W      = $clog2(SETS);
	localparam int WORD_W     = $clog2(LINE_WORDS);
	localparam int LINE_OFF_W = WORD_W + $clog2(dcache_pkg::BE_W);
	localparam int TAG_W      = dcache_pkg::ADDR_W - IDX_W - LINE_OFF_W;

	typedef struct packed {
		dcache_pkg::line_state_e state;
		logic [TAG_W-1:0]        tag;
	} tag_entry_t;

	tag_entry_t                    tag_rentry;
	tag_entry_t                    tag_wentry;
	logic                          tag_we;
	logic                          data_we;
	logic [dcache_pkg::DATA_W-1:0] data_rdata;
	logic [dcache_pkg::DATA_W-1:0] data_wdata;
	logic [IDX_W-1:0]              ram_index;
	logic [WORD_W-1:0]             ram_word;
	logic                          grant;
	logic                          rvalid;

	dcache_lookup_if #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) lk_if ();

	dcache_ram #(.DEPTH(SETS), .payload_t(tag_entry_t)) tag_ram_inst (
		.clk_i   (clk_i),
		.rst_ni  (rst_ni),
		.raddr_i (ram_index),
		.rdata_o (tag_rentry),
		.we_i    (tag_we),
		.waddr_i (ram_index),
		.wdata_i (tag_wentry)
	);

	// One word per entry, addressed by {index, word}
	dcache_ram #(
		.DEPTH     (SETS * LINE_WORDS),
		.payload_t (logic [dcache_pkg::DATA_W-1:0])
	) data_ram_inst (
		.clk_i   (clk_i),
		.rst_ni  (rst_ni),
		.raddr_i ({ram_index, ram_word}),
		.rdata_o (data_rdata),
		.we_i    (data_we),
		.waddr_i ({ram_index, ram_word}),
		.wdata_i (data_wdata)
	);

	dcache_lookup #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) lookup_inst (
		.addr_i      (addr_i),
		.tag_entry_i (tag_rentry),
		.lk          (lk_if.lookup)
	);

	dcache_ctrl #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) ctrl_inst (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.req_i          (req_i),
		.we_i           (we_i),
		.be_i           (be_i),
		.wdata_i        (wdata_i),
		.lk             (lk_if.ctrl),
		.ram_rdata_i    (data_rdata),
		.tag_we_o       (tag_we),
		.tag_wentry_o   (tag_wentry),
		.data_we_o      (data_we),
		.data_wdata_o   (data_wdata),
		.ram_index_o    (ram_index),
		.ram_word_o     (ram_word),
		.grant_o        (grant),
		.rvalid_o       (rvalid),
		.tl_a_valid_o   (tl_a_valid_o),
		.tl_a_ready_i   (tl_a_ready_i),
		.tl_a_opcode_o  (tl_a_opcode_o),
		.tl_a_param_o   (tl_a_param_o),
		.tl_a_address_o (tl_a_address_o),
		.tl_c_valid_o   (tl_c_valid_o),
		.tl_c_ready_i   (tl_c_ready_i),
		.tl_c_opcode_o  (tl_c_opcode_o),
		.tl_c_param_o   (tl_c_param_o),
		.tl_c_address_o (tl_c_address_o),
		.tl_c_data_o    (tl_c_data_o),
		.tl_d_valid_i   (tl_d_valid_i),
		.tl_d_ready_o   (tl_d_ready_o),
		.tl_d_opcode_i  (tl_d_opcode_i),
		.tl_d_sink_i    (tl_d_sink_i),
		.tl_d_data_i    (tl_d_data_i),
		.tl_e_valid_o   (tl_e_valid_o),
		.tl_e_ready_i   (tl_e_ready_i),
		.tl_e_sink_o    (tl_e_sink_o)
	);

	dcache_resp resp_inst (
		.clk_i    (clk_i),
		.rst_ni   (rst_ni),
		.grant_i  (grant),
		.rvalid_i (rvalid),
		.rdata_i  (data_rdata),
		.gnt_o    (gnt_o),
		.rvalid_o (rvalid_o),
		.rdata_o  (rdata_o)
	);

endmodule

`default_nettype wire

//--- verilog/dcache_resp.sv
// CPU response registers for grant, read valid and read data
`timescale 1ns/1ps
`default_nettype none

module dcache_resp (
	input  logic                          clk_i,
	input  logic                          rst_ni,

	// Strobes from the controller
	input  logic                          grant_i,
	input  logic                          rvalid_i,
	// Data array word at the selected read address
	input  logic [dcache_pkg::DATA_W-1:0] rdata_i,

	output logic                          gnt_o,
	output logic                          rvalid_o,
	output logic [dcache_pkg::DATA_W-1:0] rdata_o
);

	// Single-cycle pulses toward the CPU
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			gnt_o    <= 1'b0;
			rvalid_o <= 1'b0;
		end else begin
			gnt_o    <= grant_i;
			rvalid_o <= rvalid_i;
		end
	end

	// Holds the last word returned
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			rdata_o <= '0;
		end else if (rvalid_i) begin
			rdata_o <= rdata_i;
		end
	end

endmodule

`default_nettype wire

//--- verilog/dcache_ctrl.sv
// Miss, eviction and refill FSM with TileLink channel registers and array write control
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
	parameter int  SETS       = 32,
	parameter int  LINE_WORDS = 8,
	localparam int IDX_W      = $clog2(SETS),
	localparam int WORD_W     = $clog2(LINE_WORDS),
	localparam int LINE_OFF_W = WORD_W + $clog2(dcache_pkg::BE_W),
	localparam int TAG_W      = dcache_pkg::ADDR_W - IDX_W - LINE_OFF_W
) (
	input  logic                          clk_i,
	input  logic                          rst_ni,
	input  logic                          req_i,
	input  logic                          we_i,
	input  logic [dcache_pkg::BE_W-1:0]   be_i,
	input  logic [dcache_pkg::DATA_W-1:0] wdata_i,
	dcache_lookup_if.ctrl                 lk,
	input  logic [dcache_pkg::DATA_W-1:0] ram_rdata_i,
	output logic                          tag_we_o,
	output logic [TAG_W+1:0]              tag_wentry_o,
	output logic                          data_we_o,
	output logic [dcache_pkg::DATA_W-1:0] data_wdata_o,
	output logic [IDX_W-1:0]              ram_index_o,
	output logic [WORD_W-1:0]             ram_word_o,
	output logic                          grant_o,
	output logic                          rvalid_o,
	output logic                          tl_a_valid_o,
	input  logic                          tl_a_ready_i,
	output logic [2:0]                    tl_a_opcode_o,
	output logic [2:0]                    tl_a_param_o,
	output logic [dcache_pkg::ADDR_W-1:0] tl_a_address_o,
	output logic                          tl_c_valid_o,
	input  logic                          tl_c_ready_i,
	output logic [2:0]                    tl_c_opcode_o,
	output logic [2:0]                    tl_c_param_o,
	output logic [dcache_pkg::ADDR_W-1:0] tl_c_address_o,
	output logic [dcache_pkg::DATA_W-1:0] tl_c_data_o,
	input  logic                          tl_d_valid_i,
	output logic                          tl_d_ready_o,
	input  logic [2:0]                    tl_d_opcode_i,
	input  logic [dcache_pkg::SINK_W-1:0] tl_d_sink_i,
	input  logic [dcache_pkg::DATA_W-1:0] tl_d_data_i,
	output logic                          tl_e_valid_o,
	input  logic                          tl_e_ready_i,
	output logic [dcache_pkg::SINK_W-1:0] tl_e_sink_o
);

	typedef enum logic [2:0] {
		S_IDLE, S_RELEASE, S_REL_WAIT, S_ACQUIRE, S_GRANT_WAIT, S_ACK, S_RESPOND
	} state_e;

	state_e                          state_q;
	logic [WORD_W-1:0]               beat_q;
	logic                            a_fire;
	logic                            c_fire;
	logic                            c_done;
	logic                            d_fire;
	logic                            e_fire;
	logic                            last_beat;
	logic                            hit_ok;

	// Pending request, stable from acceptance until the FSM is idle again
	logic [IDX_W-1:0]                pend_index_q;
	logic [TAG_W-1:0]                pend_tag_q;
	logic [WORD_W-1:0]               pend_word_q;
	logic                            pend_store_q;
	logic [dcache_pkg::DATA_W-1:0]   pend_wdata_q;
	logic [dcache_pkg::BE_W-1:0]     pend_be_q;
	logic [dcache_pkg::ADDR_W-1:0]   pend_vaddr_q;
	logic                            pend_vdirty_q;
	logic                            pend_vshared_q;

	logic [dcache_pkg::BE_W-1:0]     be_sel;
	logic [dcache_pkg::DATA_W-1:0]   wd_sel;
	logic [dcache_pkg::DATA_W-1:0]   merged;

	assign a_fire    = tl_a_valid_o && tl_a_ready_i;
	assign c_fire    = tl_c_valid_o && tl_c_ready_i;
	assign d_fire    = tl_d_valid_i && tl_d_ready_o;
	assign e_fire    = tl_e_valid_o && tl_e_ready_i;
	assign last_beat = (beat_q == WORD_W'(LINE_WORDS - 1));
	// A clean Release is a single beat
	assign c_done    = c_fire && (!pend_vdirty_q || last_beat);
	// Stores to a shared line go down the miss path
	assign hit_ok    = lk.hit && !(we_i && lk.shared);

	// Byte-enable merge of store data into the stored word
	always_comb begin
		for (int b = 0; b < dcache_pkg::BE_W; b++) begin
			merged[8*b +: 8] = be_sel[b] ? wd_sel[8*b +: 8] : ram_rdata_i[8*b +: 8];
		end
	end

	assign data_wdata_o = (state_q == S_GRANT_WAIT) ? tl_d_data_i : merged;

	always_comb begin
		ram_index_o  = lk.index;
		ram_word_o   = lk.word;
		tag_we_o     = 1'b0;
		tag_wentry_o = '0;
		data_we_o    = 1'b0;
		be_sel       = be_i;
		wd_sel       = wdata_i;
		grant_o      = 1'b0;
		rvalid_o     = 1'b0;
		case (state_q)
			S_IDLE: begin
				if (req_i) begin
					grant_o = 1'b1;
					if (hit_ok && !we_i) begin
						rvalid_o = 1'b1;
					end else if (hit_ok) begin
						tag_we_o     = 1'b1;
						tag_wentry_o = {dcache_pkg::ST_TT, lk.tag};
						data_we_o    = 1'b1;
					end
				end
			end
			S_RELEASE: begin
				// Look one word ahead when the current beat is taken
				ram_index_o = pend_index_q;
				ram_word_o  = c_fire ? beat_q + 1'b1 : beat_q;
			end
			S_GRANT_WAIT: begin
				ram_index_o = pend_index_q;
				ram_word_o  = beat_q;
				if (d_fire && tl_d_opcode_i == dcache_pkg::D_GRANT_DATA) begin
					data_we_o = 1'b1;
					if (last_beat) begin
						tag_we_o     = 1'b1;
						tag_wentry_o = {pend_store_q ? dcache_pkg::ST_T : dcache_pkg::ST_B,
						                pend_tag_q};
					end
				end
			end
			S_RESPOND: begin
				ram_index_o = pend_index_q;
				ram_word_o  = pend_word_q;
				be_sel      = pend_be_q;
				wd_sel      = pend_wdata_q;
				if (pend_store_q) begin
					tag_we_o     = 1'b1;
					tag_wentry_o = {dcache_pkg::ST_TT, pend_tag_q};
					data_we_o    = 1'b1;
				end else begin
					rvalid_o = 1'b1;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q      <= S_IDLE;
			beat_q       <= '0;
			tl_a_valid_o <= 1'b0;
			tl_c_valid_o <= 1'b0;
			tl_d_ready_o <= 1'b0;
			tl_e_valid_o <= 1'b0;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (req_i && !hit_ok) begin
						state_q <= lk.valid ? S_RELEASE : S_ACQUIRE;
						beat_q  <= '0;
					end
				end
				S_RELEASE: begin
					tl_c_valid_o <= !c_done;
					if (c_fire) begin
						beat_q <= beat_q + 1'b1;
					end
					if (c_done) begin
						state_q      <= S_REL_WAIT;
						tl_d_ready_o <= 1'b1;
					end
				end
				S_REL_WAIT: begin
					if (d_fire && tl_d_opcode_i == dcache_pkg::D_RELEASE_ACK) begin
						state_q      <= S_ACQUIRE;
						tl_d_ready_o <= 1'b0;
					end
				end
				S_ACQUIRE: begin
					tl_a_valid_o <= !a_fire;
					if (a_fire) begin
						state_q      <= S_GRANT_WAIT;
						beat_q       <= '0;
						tl_d_ready_o <= 1'b1;
					end
				end
				S_GRANT_WAIT: begin
					if (d_fire && tl_d_opcode_i == dcache_pkg::D_GRANT_DATA) begin
						beat_q <= beat_q + 1'b1;
						if (last_beat) begin
							state_q      <= S_ACK;
							tl_d_ready_o <= 1'b0;
							tl_e_valid_o <= 1'b1;
						end
					end
				end
				S_ACK: begin
					if (e_fire) begin
						state_q      <= S_RESPOND;
						tl_e_valid_o <= 1'b0;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// Pending request and channel fields, only meaningful while the matching valid is high
	always_ff @(posedge clk_i) begin
		if (state_q == S_IDLE && req_i) begin
			pend_index_q   <= lk.index;
			pend_tag_q     <= lk.tag;
			pend_word_q    <= lk.word;
			pend_store_q   <= we_i;
			pend_wdata_q   <= wdata_i;
			pend_be_q      <= be_i;
			pend_vaddr_q   <= lk.victim_addr;
			pend_vdirty_q  <= lk.dirty;
			pend_vshared_q <= lk.shared;
		end
		if (state_q == S_ACQUIRE) begin
			tl_a_opcode_o  <= dcache_pkg::A_ACQUIRE_BLOCK;
			tl_a_param_o   <= pend_store_q ? dcache_pkg::NTOT : dcache_pkg::NTOB;
			tl_a_address_o <= {pend_tag_q, pend_index_q, {LINE_OFF_W{1'b0}}};
		end
		if (state_q == S_RELEASE) begin
			tl_c_opcode_o  <= pend_vdirty_q ? dcache_pkg::C_RELEASE_DATA : dcache_pkg::C_RELEASE;
			tl_c_param_o   <= pend_vshared_q ? dcache_pkg::BTON : dcache_pkg::TTON;
			tl_c_address_o <= pend_vaddr_q;
			tl_c_data_o    <= ram_rdata_i;
		end
		// GrantAck echoes the sink of the grant
		if (state_q == S_GRANT_WAIT && d_fire) begin
			tl_e_sink_o <= tl_d_sink_i;
		end
	end

endmodule

`default_nettype wire

//--- verilog/dcache_lookup.sv
// Address split, tag compare and line state classification
`timescale 1ns/1ps
`default_nettype none

module dcache_lookup #(
	parameter int  SETS       = 32,
	parameter int  LINE_WORDS = 8,
	localparam int IDX_W      = $clog2(SETS),
	localparam int WORD_W     = $clog2(LINE_WORDS),
	localparam int BYTE_W     = $clog2(dcache_pkg::BE_W),
	localparam int LINE_OFF_W = WORD_W + BYTE_W,
	localparam int TAG_W      = dcache_pkg::ADDR_W - IDX_W - LINE_OFF_W
) (
	input  logic [dcache_pkg::ADDR_W-1:0] addr_i,
	// Entry layout is {state, tag}
	input  logic [TAG_W+1:0]              tag_entry_i,
	dcache_lookup_if.lookup               lk
);

	dcache_pkg::line_state_e line_state;
	logic [TAG_W-1:0]        stored_tag;

	assign line_state = dcache_pkg::line_state_e'(tag_entry_i[TAG_W +: 2]);
	assign stored_tag = tag_entry_i[TAG_W-1:0];

	// Byte offset bits are dropped, the CPU addresses whole words
	assign lk.word  = addr_i[BYTE_W +: WORD_W];
	assign lk.index = addr_i[LINE_OFF_W +: IDX_W];
	assign lk.tag   = addr_i[dcache_pkg::ADDR_W-1 -: TAG_W];

	assign lk.valid  = (line_state != dcache_pkg::ST_N);
	assign lk.dirty  = (line_state == dcache_pkg::ST_TT);
	assign lk.shared = (line_state == dcache_pkg::ST_B);
	assign lk.hit    = lk.valid && (stored_tag == lk.tag);

	// Direct mapped, the indexed line is always the victim
	assign lk.victim_addr = {stored_tag, lk.index, {LINE_OFF_W{1'b0}}};

endmodule

`default_nettype wire

//--- verilog/dcache_ram.sv
// Generic array with asynchronous read and clocked write
`timescale 1ns/1ps
`default_nettype none

module dcache_ram #(
	parameter int  DEPTH     = 32,
	parameter type payload_t = logic [63:0],
	localparam int AW        = $clog2(DEPTH)
) (
	input  logic          clk_i,
	input  logic          rst_ni,

	input  logic [AW-1:0] raddr_i,
	output payload_t      rdata_o,

	input  logic          we_i,
	input  logic [AW-1:0] waddr_i,
	input  payload_t      wdata_i
);

	payload_t mem_q [DEPTH];

	// Read port is combinational so a hit resolves in the request cycle
	assign rdata_o = mem_q[raddr_i];

	// Cleared store, so every tag entry starts out invalid
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem_q[i] <= '0;
			end
		end else if (we_i) begin
			mem_q[waddr_i] <= wdata_i;
		end
	end

endmodule

`default_nettype wire

//--- verilog/dcache_lookup_if.sv
// Interface for the decoded CPU request and the tag lookup result
`timescale 1ns/1ps
`default_nettype none

interface dcache_lookup_if #(
	parameter int SETS       = 32,
	parameter int LINE_WORDS = 8
);
	localparam int IDX_W      = $clog2(SETS);
	localparam int WORD_W     = $clog2(LINE_WORDS);
	localparam int LINE_OFF_W = WORD_W + $clog2(dcache_pkg::BE_W);
	localparam int TAG_W      = dcache_pkg::ADDR_W - IDX_W - LINE_OFF_W;

	// Fields of the CPU address
	logic [IDX_W-1:0]              index;
	logic [WORD_W-1:0]             word;
	logic [TAG_W-1:0]              tag;

	// State of the indexed line
	logic                          hit;
	logic                          valid;
	logic                          dirty;
	logic                          shared;
	logic [dcache_pkg::ADDR_W-1:0] victim_addr;

	modport lookup (output index, word, tag, hit, valid, dirty, shared, victim_addr);
	modport ctrl   (input index, word, tag, hit, valid, dirty, shared, victim_addr);

endinterface

`default_nettype wire

//--- verilog/dcache_pkg.sv
// Bus widths, cache line states, TileLink opcodes and permission codes
`default_nettype none

package dcache_pkg;

	// CPU and TileLink bus widths
	localparam int ADDR_W = 64;
	localparam int DATA_W = 64;
	localparam int BE_W   = DATA_W / 8;
	localparam int SINK_W = 4;

	// Line permission as held by this cache
	typedef enum logic [1:0] {
		ST_N  = 2'd0,
		ST_B  = 2'd1,
		ST_T  = 2'd2,
		ST_TT = 2'd3
	} line_state_e;

	// Channel opcodes
	localparam logic [2:0] A_ACQUIRE_BLOCK = 3'd6;
	localparam logic [2:0] C_RELEASE       = 3'd6;
	localparam logic [2:0] C_RELEASE_DATA  = 3'd7;
	localparam logic [2:0] D_GRANT_DATA    = 3'd5;
	localparam logic [2:0] D_RELEASE_ACK   = 3'd6;

	// Grow params on A
	localparam logic [2:0] NTOB = 3'd0;
	localparam logic [2:0] NTOT = 3'd1;

	// Shrink params on C
	localparam logic [2:0] TTON = 3'd1;
	localparam logic [2:0] BTON = 3'd2;

endpackage

`default_nettype wire
